//--- design/l2_cache.sv
`timescale 1ns/1ps
`default_nettype none

module l2_cache (
    input  logic                   clk,
    input  logic                   proc_reset,
    input  l2_cache_pkg::cpu_req_t cpu_req,
    output l2_cache_pkg::line_t    rdata,
    output logic                   stall,
    output l2_cache_pkg::mem_req_t mem_req,
    input  l2_cache_pkg::mem_rsp_t mem_rsp
);
    import l2_cache_pkg::*;

    set_entry_t set_entry;
    lookup_t    lookup;
    store_cmd_t cmd;

    // arrays, read out for the requested set
    set_storage u_set_storage (
        .clk        (clk),
        .proc_reset (proc_reset),
        .cpu_req    (cpu_req),
        .mem_rdata  (mem_rsp.rdata),
        .cmd        (cmd),
        .set_entry  (set_entry)
    );

    set_lookup u_set_lookup (
        .cpu_req   (cpu_req),
        .set_entry (set_entry),
        .result    (lookup),
        .rdata     (rdata)
    );

    // miss handling and memory port
    miss_controller u_miss_controller (
        .clk        (clk),
        .proc_reset (proc_reset),
        .cpu_req    (cpu_req),
        .lookup     (lookup),
        .set_entry  (set_entry),
        .mem_rsp    (mem_rsp),
        .cmd        (cmd),
        .mem_req    (mem_req),
        .stall      (stall)
    );

endmodule

`default_nettype wire

//--- design/l2_cache_pkg.sv
`default_nettype none

package l2_cache_pkg;

    localparam int LINE_BITS  = 128;
    localparam int ADDR_BITS  = 28;
    localparam int INDEX_BITS = 5;
    localparam int NUM_SETS   = 32;
    localparam int TAG_BITS   = ADDR_BITS - INDEX_BITS;
    localparam int NUM_WAYS   = 2;

    typedef logic [LINE_BITS-1:0] line_t;

    typedef struct packed {
        logic [TAG_BITS-1:0]   tag;
        logic [INDEX_BITS-1:0] index;
    } addr_fields_t;

    // flat word on the memory bus, tag/index inside the cache
    typedef union packed {
        logic [ADDR_BITS-1:0] flat;
        addr_fields_t         fields;
    } line_addr_u;

    typedef struct packed {
        logic       read;
        logic       write;
        line_addr_u addr;
        line_t      wdata;
    } cpu_req_t;

    typedef struct packed {
        logic       read;
        logic       write;
        line_addr_u addr;
        line_t      wdata;
    } mem_req_t;

    typedef struct packed {
        line_t rdata;
        logic  ready;
    } mem_rsp_t;

    typedef struct packed {
        logic                valid;
        logic                dirty;
        logic [TAG_BITS-1:0] tag;
        line_t               data;
    } way_entry_t;

    // lru names the way to evict next
    typedef struct packed {
        way_entry_t [NUM_WAYS-1:0] ways;
        logic                      lru;
    } set_entry_t;

    typedef struct packed {
        logic hit;
        logic hit_way;
        logic victim_way;
        logic victim_dirty;
    } lookup_t;

    typedef enum logic [1:0] {
        OP_NONE,
        OP_WRITE_HIT,
        OP_TOUCH,
        OP_FILL
    } store_op_e;

    typedef struct packed {
        store_op_e op;
        logic      way;
    } store_cmd_t;

endpackage

`default_nettype wire

//--- design/miss_controller.sv
`timescale 1ns/1ps
`default_nettype none

module miss_controller (
    input  logic                     clk,
    input  logic                     proc_reset,
    input  l2_cache_pkg::cpu_req_t   cpu_req,
    input  l2_cache_pkg::lookup_t    lookup,
    input  l2_cache_pkg::set_entry_t set_entry,
    input  l2_cache_pkg::mem_rsp_t   mem_rsp,
    output l2_cache_pkg::store_cmd_t cmd,
    output l2_cache_pkg::mem_req_t   mem_req,
    output logic                     stall
);
    import l2_cache_pkg::*;

    typedef enum logic [1:0] {
        LOOKUP,
        WRITEBACK,
        REFILL
    } state_e;

    state_e     state;
    state_e     state_next;
    way_entry_t victim;
    logic       req_valid;

    assign req_valid = cpu_req.read | cpu_req.write;

    // storage is frozen during a miss, so the victim stays put
    assign victim = set_entry.ways[lookup.victim_way];

    assign stall = proc_reset || (state != LOOKUP) || (req_valid && !lookup.hit);

    always_ff @(posedge clk)
    begin
        if (proc_reset)
            state <= LOOKUP;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        cmd.op     = OP_NONE;
        cmd.way    = lookup.hit_way;
        mem_req    = '0;
        case (state)
            LOOKUP:
            begin
                if (req_valid && lookup.hit)
                    cmd.op = cpu_req.write ? OP_WRITE_HIT : OP_TOUCH;
                else if (req_valid)
                    state_next = lookup.victim_dirty ? WRITEBACK : REFILL;
            end
            WRITEBACK:
            begin
                mem_req.write             = 1'b1;
                mem_req.addr.fields.tag   = victim.tag;
                mem_req.addr.fields.index = cpu_req.addr.fields.index;
                mem_req.wdata             = victim.data;
                if (mem_rsp.ready)
                    state_next = REFILL;
            end
            REFILL:
            begin
                mem_req.read      = 1'b1;
                mem_req.addr.flat = cpu_req.addr.flat;
                cmd.way           = lookup.victim_way;
                if (mem_rsp.ready)
                begin
                    cmd.op     = OP_FILL;
                    state_next = LOOKUP;
                end
            end
            default:
            begin
                state_next = LOOKUP;
            end
        endcase
    end

    assert property (@(posedge clk) disable iff (proc_reset)
        !(mem_req.read && mem_req.write));

    // request stays put until memory takes it
    assert property (@(posedge clk) disable iff (proc_reset)
        (mem_req.read || mem_req.write) && !mem_rsp.ready |=> $stable(mem_req));

endmodule

`default_nettype wire

//--- design/set_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module set_lookup (
    input  l2_cache_pkg::cpu_req_t   cpu_req,
    input  l2_cache_pkg::set_entry_t set_entry,
    output l2_cache_pkg::lookup_t    result,
    output l2_cache_pkg::line_t      rdata
);
    import l2_cache_pkg::*;

    logic [NUM_WAYS-1:0] hit_vec;
    logic                victim;

    always_comb
    begin
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            hit_vec[w] = set_entry.ways[w].valid &&
                         (set_entry.ways[w].tag == cpu_req.addr.fields.tag);
        end
    end

    // empty ways fill first, way 0 before way 1
    always_comb
    begin
        if (!set_entry.ways[0].valid)
            victim = 1'b0;
        else if (!set_entry.ways[1].valid)
            victim = 1'b1;
        else
            victim = set_entry.lru;
    end

    always_comb
    begin
        result.hit          = |hit_vec;
        result.hit_way      = hit_vec[1];
        result.victim_way   = victim;
        result.victim_dirty = set_entry.ways[victim].valid && set_entry.ways[victim].dirty;
    end

    always_comb
    begin
        if (|hit_vec)
            rdata = set_entry.ways[hit_vec[1]].data;
        else
            rdata = '0;
    end

    // a tag is only ever allocated once per set
    always_comb
    begin
        assert (!(hit_vec[0] && hit_vec[1]));
    end

endmodule

`default_nettype wire

//--- design/set_storage.sv
`timescale 1ns/1ps
`default_nettype none

module set_storage (
    input  logic                     clk,
    input  logic                     proc_reset,
    input  l2_cache_pkg::cpu_req_t   cpu_req,
    input  l2_cache_pkg::line_t      mem_rdata,
    input  l2_cache_pkg::store_cmd_t cmd,
    output l2_cache_pkg::set_entry_t set_entry
);
    import l2_cache_pkg::*;

    logic [INDEX_BITS-1:0] idx;

    // payload arrays
    line_t               data_q [NUM_SETS][NUM_WAYS];
    logic [TAG_BITS-1:0] tag_q  [NUM_SETS][NUM_WAYS];

    // per-set state bits
    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
    logic [NUM_WAYS-1:0] dirty_q [NUM_SETS];
    logic                lru_q   [NUM_SETS];

    assign idx = cpu_req.addr.fields.index;

    always_comb
    begin
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            set_entry.ways[w].valid = valid_q[idx][w];
            set_entry.ways[w].dirty = dirty_q[idx][w];
            set_entry.ways[w].tag   = tag_q[idx][w];
            set_entry.ways[w].data  = data_q[idx][w];
        end
        set_entry.lru = lru_q[idx];
    end

    always_ff @(posedge clk)
    begin
        case (cmd.op)
            OP_WRITE_HIT:
            begin
                data_q[idx][cmd.way] <= cpu_req.wdata;
            end
            OP_FILL:
            begin
                data_q[idx][cmd.way] <= mem_rdata;
                tag_q[idx][cmd.way]  <= cpu_req.addr.fields.tag;
            end
            default:
            begin
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (proc_reset)
        begin
            for (int s = 0; s < NUM_SETS; s++)
            begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                lru_q[s]   <= 1'b0;
            end
        end
        else
        begin
            case (cmd.op)
                OP_WRITE_HIT:
                begin
                    dirty_q[idx][cmd.way] <= 1'b1;
                end
                OP_FILL:
                begin
                    valid_q[idx][cmd.way] <= 1'b1;
                    dirty_q[idx][cmd.way] <= 1'b0;
                end
                default:
                begin
                end
            endcase
            // any access makes the other way the next victim
            if (cmd.op != OP_NONE)
                lru_q[idx] <= ~cmd.way;
        end
    end

    // controller only writes into a line it found valid
    assert property (@(posedge clk) disable iff (proc_reset)
        cmd.op == OP_WRITE_HIT |-> set_entry.ways[cmd.way].valid);

endmodule

`default_nettype wire

//--- l2_cache.f
design/l2_cache_pkg.sv
design/set_storage.sv
design/set_lookup.sv
design/miss_controller.sv
design/l2_cache.sv
test/tb_clock_gen.sv
test/tb_l2_cache.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f l2_cache.f --top-module tb_l2_cache \
        -o sim_l2_cache \
    && ./obj_dir/sim_l2_cache 2>&1 | tee /dev/stderr | grep -q "Regression passed" \
    && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic proc_reset
);

    // 4 ns period
    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held over five rising edges
    initial
    begin
        proc_reset = 1'b1;
        repeat (5) @(posedge clk);
        proc_reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- test/tb_l2_cache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_l2_cache;
    import l2_cache_pkg::*;

    // about four times the expected length of all tests
    localparam int MAX_CYCLES = 2000;
    localparam logic [TAG_BITS-1:0] TAG_A = 23'h0000a1;
    localparam logic [TAG_BITS-1:0] TAG_B = 23'h012345;
    localparam logic [TAG_BITS-1:0] TAG_C = 23'h07ff00;

    logic     clk;
    logic     proc_reset;
    cpu_req_t cpu_req = '0;
    mem_rsp_t mem_rsp = '0;
    line_t    rdata;
    logic     stall;
    mem_req_t mem_req;

    // memory model
    line_t      mem_q [logic [ADDR_BITS-1:0]];
    line_addr_u last_rd_addr;
    line_addr_u last_wr_addr;
    line_t      last_wr_data;
    int         mem_reads;
    int         mem_writes;
    int         wait_left;
    bit         busy;

    // reference model with the latest value of each line, expected tags and LRU
    line_t               arch_q    [logic [ADDR_BITS-1:0]];
    bit                  ref_valid [NUM_SETS][NUM_WAYS];
    bit                  ref_dirty [NUM_SETS][NUM_WAYS];
    logic [TAG_BITS-1:0] ref_tag   [NUM_SETS][NUM_WAYS];
    bit                  ref_lru   [NUM_SETS];

    logic [31:0] lfsr_q = 32'h2677;
    int          cycles = 0;

    tb_clock_gen u_clock_gen (
        .clk        (clk),
        .proc_reset (proc_reset)
    );

    l2_cache DUT (
        .clk        (clk),
        .proc_reset (proc_reset),
        .cpu_req    (cpu_req),
        .rdata      (rdata),
        .stall      (stall),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp)
    );

    // taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    // contents of a line never written
    function automatic line_t pattern(input logic [ADDR_BITS-1:0] a);
        return {4'h9, a, 4'h6, ~a, a ^ 28'h5a5a5a5, 4'hc, 4'h3, ~a ^ 28'h0f0f0f0};
    endfunction

    function automatic line_t arch_read(input logic [ADDR_BITS-1:0] a);
        if (arch_q.exists(a))
            return arch_q[a];
        return pattern(a);
    endfunction

    function automatic logic [ADDR_BITS-1:0] make_addr(input logic [TAG_BITS-1:0] tag,
                                                       input logic [INDEX_BITS-1:0] idx);
        return {tag, idx};
    endfunction

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_line(input line_t got, input line_t exp, input string what);
        if (got !== exp)
        begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_addr(input line_addr_u got, input line_addr_u exp, input string what);
        if (got.flat !== exp.flat)
        begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got.flat, exp.flat);
            abort_run();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    // memory answers after 0 to 3 extra cycles
    always @(posedge clk)
    begin
        if (proc_reset)
        begin
            mem_rsp <= '0;
            busy = 1'b0;
        end
        else if (mem_rsp.ready)
        begin
            if (mem_req.write)
            begin
                mem_q[mem_req.addr.flat] = mem_req.wdata;
                last_wr_addr = mem_req.addr;
                last_wr_data = mem_req.wdata;
                mem_writes++;
            end
            else
            begin
                last_rd_addr = mem_req.addr;
                mem_reads++;
            end
            mem_rsp.ready <= 1'b0;
            busy = 1'b0;
        end
        else if (mem_req.read || mem_req.write)
        begin
            if (!busy)
            begin
                busy = 1'b1;
                wait_left = int'(lfsr_bits(2));
            end
            if (wait_left == 0)
            begin
                mem_rsp.ready <= 1'b1;
                mem_rsp.rdata <= mem_q.exists(mem_req.addr.flat) ?
                                 mem_q[mem_req.addr.flat] : pattern(mem_req.addr.flat);
            end
            else
                wait_left--;
        end
    end

    // one request checked against the reference model
    task automatic access(input logic wr, input logic [ADDR_BITS-1:0] a, input line_t d);
        cpu_req_t              req;
        logic [INDEX_BITS-1:0] idx;
        logic                  hit;
        logic                  way;
        logic                  wb;
        line_addr_u            wb_addr;
        int                    rd0;
        int                    wr0;
        req.read = !wr;
        req.write = wr;
        req.addr.flat = a;
        req.wdata = d;
        idx = req.addr.fields.index;
        hit = 1'b0;
        way = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            if (ref_valid[idx][w] && ref_tag[idx][w] == req.addr.fields.tag)
            begin
                hit = 1'b1;
                way = w[0];
            end
        end
        if (!hit)
        begin
            // an empty way before the LRU way
            if (!ref_valid[idx][0])
                way = 1'b0;
            else if (!ref_valid[idx][1])
                way = 1'b1;
            else
                way = ref_lru[idx];
        end
        wb = !hit && ref_valid[idx][way] && ref_dirty[idx][way];
        wb_addr.flat = make_addr(ref_tag[idx][way], idx);
        rd0 = mem_reads;
        wr0 = mem_writes;
        @(posedge clk);
        cpu_req <= req;
        @(negedge clk);
        check_bit(stall, !hit, "stall in request cycle");
        while (stall)
            @(negedge clk);
        check_bit(mem_reads != rd0, !hit, "refill read issued");
        check_bit(mem_writes != wr0, wb, "write-back issued");
        if (!hit)
            check_addr(last_rd_addr, req.addr, "refill address");
        if (wb)
        begin
            check_addr(last_wr_addr, wb_addr, "write-back address");
            check_line(last_wr_data, arch_read(wb_addr.flat), "write-back data");
        end
        if (wr)
            arch_q[a] = d;
        else
            check_line(rdata, arch_read(a), "read data");
        ref_valid[idx][way] = 1'b1;
        ref_tag[idx][way] = req.addr.fields.tag;
        ref_dirty[idx][way] = (hit && ref_dirty[idx][way]) || wr;
        ref_lru[idx] = ~way;
    endtask

    task automatic read_new_line();
        access(1'b0, make_addr(TAG_A, 5'd9), '0);
    endtask

    task automatic read_again();
        access(1'b0, make_addr(TAG_A, 5'd9), '0);
    endtask

    task automatic write_then_read();
        access(1'b1, make_addr(TAG_A, 5'd9), {4{32'hc0de0001}});
        access(1'b0, make_addr(TAG_A, 5'd9), '0);
    endtask

    task automatic evict_dirty_line();
        int w0;
        access(1'b0, make_addr(TAG_B, 5'd9), '0);
        // dirty way 0 and touch way 1 so way 0 is next out
        access(1'b1, make_addr(TAG_A, 5'd9), {4{32'hc0de0003}});
        access(1'b0, make_addr(TAG_B, 5'd9), '0);
        w0 = mem_writes;
        access(1'b0, make_addr(TAG_C, 5'd9), '0);
        check_bit(mem_writes != w0, 1'b1, "dirty victim written back");
        access(1'b0, make_addr(TAG_A, 5'd9), '0);
    endtask

    task automatic write_miss_allocate();
        access(1'b1, make_addr(TAG_A, 5'd21), {4{32'hfeed0002}});
        access(1'b0, make_addr(TAG_A, 5'd21), '0);
        access(1'b0, make_addr(TAG_B, 5'd21), '0);
        access(1'b0, make_addr(TAG_C, 5'd21), '0);
        access(1'b0, make_addr(TAG_A, 5'd21), '0);
    endtask

    task automatic random_traffic();
        logic [TAG_BITS-1:0]   tags [3];
        logic [INDEX_BITS-1:0] sets [2];
        int                    ssel;
        int                    tsel;
        logic                  wr;
        line_t                 d;
        tags = '{TAG_A, TAG_B, TAG_C};
        sets = '{5'd3, 5'd17};
        for (int i = 0; i < 60; i++)
        begin
            ssel = int'(lfsr_bits(1));
            tsel = int'(lfsr_bits(2) % 3);
            wr = lfsr_bit();
            d = {lfsr_bits(32), lfsr_bits(32), lfsr_bits(32), lfsr_bits(32)};
            access(wr, make_addr(tags[tsel], sets[ssel]), d);
        end
    endtask

    initial
    begin
        @(negedge clk);
        check_bit(stall, 1'b1, "stall during reset");
        while (proc_reset)
            @(negedge clk);
        check_bit(mem_req.read, 1'b0, "memory read after reset");
        check_bit(mem_req.write, 1'b0, "memory write after reset");
        read_new_line();
        read_again();
        write_then_read();
        evict_dirty_line();
        write_miss_allocate();
        random_traffic();
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire
